//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := mipsCoreTb
FILELIST := compile.f
LOG      := sim.log
PASS_MSG := SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- compile.f
hw/mipsIsaPkg.sv
hw/mipsPipePkg.sv
hw/stageReg.sv
hw/controlDecoder.sv
hw/registerFile.sv
hw/hazardUnit.sv
hw/executeUnit.sv
hw/mipsCore.sv
tests/storeChecker.sv
tests/mipsCoreTb.sv

//--- hw/controlDecoder.sv
`timescale 1ns/10ps

module controlDecoder (
    input  mipsIsaPkg::wordT  instr,
    output mipsPipePkg::ctrlT ctrl
);

    logic supported;

    always_comb begin
        // Start from an inactive bundle
        ctrl      = '0;
        supported = 1'b1;

        // Main decoder
        case (instr[31:26])
            mipsIsaPkg::opRType: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = 1'b1;
                // ALU op from the function field
                case (instr[5:0])
                    mipsIsaPkg::fnSub: ctrl.aluOp = mipsIsaPkg::aluSub;
                    mipsIsaPkg::fnAnd: ctrl.aluOp = mipsIsaPkg::aluAnd;
                    mipsIsaPkg::fnOr:  ctrl.aluOp = mipsIsaPkg::aluOr;
                    mipsIsaPkg::fnSlt: ctrl.aluOp = mipsIsaPkg::aluSlt;
                    default:           ctrl.aluOp = mipsIsaPkg::aluAdd;
                endcase
            end
            mipsIsaPkg::opLw: begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = mipsIsaPkg::aluAdd;
            end
            mipsIsaPkg::opSw: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = mipsIsaPkg::aluAdd;
            end
            mipsIsaPkg::opBeq: begin
                // Compare by subtraction, zero flag decides
                ctrl.branch = 1'b1;
                ctrl.aluOp  = mipsIsaPkg::aluSub;
            end
            mipsIsaPkg::opAddi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = mipsIsaPkg::aluAdd;
            end
            default: begin
                supported = 1'b0;
            end
        endcase
    end

    // Unknown opcode reaching decode
    always_comb begin
        if (!$isunknown(instr[31:26])) begin
            opcodeSupported: assert final (supported)
                else $error("controlDecoder: unsupported opcode %b", instr[31:26]);
        end
    end

endmodule

//--- hw/executeUnit.sv
`timescale 1ns/10ps

module executeUnit (
    input  mipsPipePkg::executeStageT stage,
    input  mipsIsaPkg::wordT          aluOutM,
    input  mipsIsaPkg::wordT          resultW,
    input  logic [1:0]                forwardA,
    input  logic [1:0]                forwardB,
    output mipsPipePkg::memoryStageT  stageOut
);

    mipsIsaPkg::wordT srcA;
    mipsIsaPkg::wordT srcB;
    mipsIsaPkg::wordT writeData;
    mipsIsaPkg::wordT aluResult;

    // Bypass muxes
    always_comb begin
        case (forwardA)
            2'b10:   srcA = aluOutM;
            2'b01:   srcA = resultW;
            default: srcA = stage.rd1;
        endcase
        case (forwardB)
            2'b10:   writeData = aluOutM;
            2'b01:   writeData = resultW;
            default: writeData = stage.rd2;
        endcase
    end

    // Immediate for addi, lw, sw
    assign srcB = stage.ctrl.aluSrc ? stage.signImm : writeData;

    always_comb begin
        case (stage.ctrl.aluOp)
            mipsIsaPkg::aluAdd: aluResult = srcA + srcB;
            mipsIsaPkg::aluSub: aluResult = srcA - srcB;
            mipsIsaPkg::aluAnd: aluResult = srcA & srcB;
            mipsIsaPkg::aluOr:  aluResult = srcA | srcB;
            // Signed compare
            mipsIsaPkg::aluSlt: aluResult = ($signed(srcA) < $signed(srcB)) ? 32'd1 : 32'd0;
            default:            aluResult = '0;
        endcase
    end

    always_comb begin
        stageOut.regWrite     = stage.ctrl.regWrite;
        stageOut.memToReg     = stage.ctrl.memToReg;
        stageOut.memWrite     = stage.ctrl.memWrite;
        stageOut.branch       = stage.ctrl.branch;
        stageOut.zero         = (aluResult == '0);
        stageOut.aluOut       = aluResult;
        // Store data takes the forwarded rt value
        stageOut.writeData    = writeData;
        // rd for R-type, rt otherwise
        stageOut.writeReg     = stage.ctrl.regDst ? stage.rd : stage.rt;
        // Word offset relative to the next instruction
        stageOut.branchTarget = stage.pcPlus4 + {stage.signImm[29:0], 2'b00};
    end

endmodule

//--- hw/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit (
    input  mipsPipePkg::executeStageT   execStage,
    input  mipsPipePkg::memoryStageT    memStage,
    input  mipsPipePkg::writebackStageT wbStage,
    input  mipsIsaPkg::regIdxT          rsD,
    input  mipsIsaPkg::regIdxT          rtD,
    input  logic                        branchD,
    input  logic                        pcSrcM,
    output logic                        stallF,
    output logic                        stallD,
    output logic                        bubbleD,
    output logic                        bubbleE,
    output logic [1:0]                  forwardA,
    output logic [1:0]                  forwardB
);

    logic lwStall;
    logic branchE;

    // Operand select: 2'b10 memory, 2'b01 writeback, 2'b00 register file
    function automatic logic [1:0] forwardSel(input mipsIsaPkg::regIdxT src);
        if (src != mipsIsaPkg::regZero && memStage.regWrite && src == memStage.writeReg) begin
            return 2'b10;
        end
        if (src != mipsIsaPkg::regZero && wbStage.regWrite && src == wbStage.writeReg) begin
            return 2'b01;
        end
        return 2'b00;
    endfunction

    always_comb begin
        forwardA = forwardSel(execStage.rs);
        forwardB = forwardSel(execStage.rt);
    end

    // Load in execute feeding decode
    assign lwStall = execStage.ctrl.memToReg && execStage.rt != mipsIsaPkg::regZero &&
                     (execStage.rt == rsD || execStage.rt == rtD);

    assign branchE = execStage.ctrl.branch;

    // Fetch waits out loads and unresolved branches
    assign stallF  = lwStall || branchD || branchE;
    assign stallD  = lwStall;
    // A branch stuck behind a load stays put instead of being flushed
    assign bubbleD = (branchD && !lwStall) || branchE || pcSrcM;
    assign bubbleE = lwStall;

    always_comb begin
        if (!$isunknown({forwardA, forwardB})) begin
            forwardLegal: assert final (forwardA != 2'b11 && forwardB != 2'b11)
                else $error("hazardUnit: unused forward select");
        end
    end

endmodule

//--- hw/mipsCore.sv
`timescale 1ns/10ps

module mipsCore #(
    parameter mipsIsaPkg::wordT resetPc = '0
) (
    input  logic                 clk,
    input  logic                 reset,
    output mipsIsaPkg::wordT     instrAddr,
    input  mipsIsaPkg::wordT     instr,
    output mipsPipePkg::dataReqT dataReq,
    input  mipsIsaPkg::wordT     readData
);

    mipsIsaPkg::wordT            pc;
    mipsIsaPkg::wordT            pcPlus4F;
    mipsPipePkg::decodeStageT    fetchPayload;
    mipsPipePkg::decodeStageT    decodeStage;
    mipsPipePkg::ctrlT           ctrlD;
    mipsIsaPkg::regIdxT          rsD;
    mipsIsaPkg::regIdxT          rtD;
    mipsIsaPkg::wordT            rd1D;
    mipsIsaPkg::wordT            rd2D;
    mipsPipePkg::executeStageT   execPayload;
    mipsPipePkg::executeStageT   execStage;
    mipsPipePkg::memoryStageT    memPayload;
    mipsPipePkg::memoryStageT    memStage;
    mipsPipePkg::writebackStageT wbPayload;
    mipsPipePkg::writebackStageT wbStage;
    mipsIsaPkg::wordT            resultW;
    logic                        stallF;
    logic                        stallD;
    logic                        bubbleD;
    logic                        bubbleE;
    logic [1:0]                  forwardA;
    logic [1:0]                  forwardB;
    logic                        pcSrcM;

    // ****************************************
    // Fetch
    // ****************************************

    assign pcPlus4F  = pc + 32'd4;
    assign instrAddr = pc;

    // Taken branch redirects, otherwise advance unless held
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= resetPc;
        end else if (pcSrcM) begin
            pc <= memStage.branchTarget;
        end else if (!stallF) begin
            pc <= pcPlus4F;
        end
    end

    assign fetchPayload.instr   = instr;
    assign fetchPayload.pcPlus4 = pcPlus4F;

    stageReg #(.payloadT(mipsPipePkg::decodeStageT), .holdUsed(1'b1)) decodeReg (
        .clk(clk), .reset(reset), .hold(stallD), .clear(bubbleD),
        .d(fetchPayload), .q(decodeStage)
    );

    // ****************************************
    // Decode
    // ****************************************

    assign rsD = decodeStage.instr[25:21];
    assign rtD = decodeStage.instr[20:16];

    controlDecoder controlDecoder_inst (.instr(decodeStage.instr), .ctrl(ctrlD));

    // Written from writeback, bypassed in the same cycle
    registerFile registerFile_inst (
        .clk(clk), .reset(reset), .raddr1(rsD), .raddr2(rtD),
        .waddr(wbStage.writeReg), .wdata(resultW), .writeEnable(wbStage.regWrite),
        .rdata1(rd1D), .rdata2(rd2D)
    );

    always_comb begin
        execPayload.ctrl    = ctrlD;
        execPayload.rd1     = rd1D;
        execPayload.rd2     = rd2D;
        // Sign extension of the 16-bit immediate
        execPayload.signImm = {{16{decodeStage.instr[15]}}, decodeStage.instr[15:0]};
        execPayload.pcPlus4 = decodeStage.pcPlus4;
        execPayload.rs      = rsD;
        execPayload.rt      = rtD;
        execPayload.rd      = decodeStage.instr[15:11];
    end

    stageReg #(.payloadT(mipsPipePkg::executeStageT)) executeReg (
        .clk(clk), .reset(reset), .hold(1'b0), .clear(bubbleE),
        .d(execPayload), .q(execStage)
    );

    hazardUnit hazardUnit_inst (
        .execStage(execStage), .memStage(memStage), .wbStage(wbStage),
        .rsD(rsD), .rtD(rtD), .branchD(ctrlD.branch), .pcSrcM(pcSrcM),
        .stallF(stallF), .stallD(stallD), .bubbleD(bubbleD), .bubbleE(bubbleE),
        .forwardA(forwardA), .forwardB(forwardB)
    );

    // ****************************************
    // Execute, memory, writeback
    // ****************************************

    executeUnit executeUnit_inst (
        .stage(execStage), .aluOutM(memStage.aluOut), .resultW(resultW),
        .forwardA(forwardA), .forwardB(forwardB), .stageOut(memPayload)
    );

    stageReg #(.payloadT(mipsPipePkg::memoryStageT)) memoryReg (
        .clk(clk), .reset(reset), .hold(1'b0), .clear(1'b0),
        .d(memPayload), .q(memStage)
    );

    // Branch resolves here
    assign pcSrcM = memStage.branch && memStage.zero;

    assign dataReq.address     = memStage.aluOut;
    assign dataReq.writeData   = memStage.writeData;
    assign dataReq.writeEnable = memStage.memWrite;

    always_comb begin
        wbPayload.regWrite = memStage.regWrite;
        wbPayload.memToReg = memStage.memToReg;
        wbPayload.readData = readData;
        wbPayload.aluOut   = memStage.aluOut;
        wbPayload.writeReg = memStage.writeReg;
    end

    stageReg #(.payloadT(mipsPipePkg::writebackStageT)) writebackReg (
        .clk(clk), .reset(reset), .hold(1'b0), .clear(1'b0),
        .d(wbPayload), .q(wbStage)
    );

    // Load data or ALU result
    assign resultW = wbStage.memToReg ? wbStage.readData : wbStage.aluOut;

endmodule

//--- hw/mipsIsaPkg.sv
package mipsIsaPkg;

    // Instruction and data word width
    localparam int instrWidth = 32;

    typedef logic [instrWidth-1:0] wordT;

    // One architectural register
    typedef logic [4:0] regIdxT;

    // Hardwired zero register
    localparam regIdxT regZero = 5'd0;

    // Primary opcodes, instr[31:26]
    typedef enum logic [5:0] {
        opRType = 6'b000000,
        opBeq   = 6'b000100,
        opAddi  = 6'b001000,
        opLw    = 6'b100011,
        opSw    = 6'b101011
    } opcodeT;

    // R-type function codes, instr[5:0]
    typedef enum logic [5:0] {
        fnAdd = 6'b100000,
        fnSub = 6'b100010,
        fnAnd = 6'b100100,
        fnOr  = 6'b100101,
        fnSlt = 6'b101010
    } functT;

    // ALU operation select
    typedef enum logic [2:0] {
        aluAnd = 3'b000,
        aluOr  = 3'b001,
        aluAdd = 3'b010,
        aluSub = 3'b110,
        aluSlt = 3'b111
    } aluOpT;

endpackage

//--- hw/mipsPipePkg.sv
package mipsPipePkg;

    // Control bundle from the decoder, all zero means no side effects
    typedef struct packed {
        logic                regWrite;
        logic                memToReg;
        logic                memWrite;
        logic                aluSrc;
        logic                regDst;
        logic                branch;
        mipsIsaPkg::aluOpT   aluOp;
    } ctrlT;

    // Fetch to decode
    typedef struct packed {
        mipsIsaPkg::wordT    instr;
        mipsIsaPkg::wordT    pcPlus4;
    } decodeStageT;

    // Decode to execute
    typedef struct packed {
        ctrlT                ctrl;
        mipsIsaPkg::wordT    rd1;
        mipsIsaPkg::wordT    rd2;
        mipsIsaPkg::wordT    signImm;
        mipsIsaPkg::wordT    pcPlus4;
        mipsIsaPkg::regIdxT  rs;
        mipsIsaPkg::regIdxT  rt;
        mipsIsaPkg::regIdxT  rd;
    } executeStageT;

    // Execute to memory
    typedef struct packed {
        logic                regWrite;
        logic                memToReg;
        logic                memWrite;
        logic                branch;
        logic                zero;
        mipsIsaPkg::wordT    aluOut;
        mipsIsaPkg::wordT    writeData;
        mipsIsaPkg::regIdxT  writeReg;
        mipsIsaPkg::wordT    branchTarget;
    } memoryStageT;

    // Memory to writeback
    typedef struct packed {
        logic                regWrite;
        logic                memToReg;
        mipsIsaPkg::wordT    readData;
        mipsIsaPkg::wordT    aluOut;
        mipsIsaPkg::regIdxT  writeReg;
    } writebackStageT;

    // Data memory request, single cycle, no handshake
    typedef struct packed {
        mipsIsaPkg::wordT    address;
        mipsIsaPkg::wordT    writeData;
        logic                writeEnable;
    } dataReqT;

endpackage

//--- hw/registerFile.sv
`timescale 1ns/10ps

module registerFile (
    input  logic                clk,
    input  logic                reset,
    input  mipsIsaPkg::regIdxT  raddr1,
    input  mipsIsaPkg::regIdxT  raddr2,
    input  mipsIsaPkg::regIdxT  waddr,
    input  mipsIsaPkg::wordT    wdata,
    input  logic                writeEnable,
    output mipsIsaPkg::wordT    rdata1,
    output mipsIsaPkg::wordT    rdata2
);

    mipsIsaPkg::wordT regs [32];

    // Architectural state starts at zero
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && waddr != mipsIsaPkg::regZero) begin
            regs[waddr] <= wdata;
        end
    end

    // Zero register, then same-cycle write bypass, then array
    function automatic mipsIsaPkg::wordT readPort(input mipsIsaPkg::regIdxT addr);
        if (addr == mipsIsaPkg::regZero) begin
            return '0;
        end
        if (writeEnable && addr == waddr) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata1 = readPort(raddr1);
        rdata2 = readPort(raddr2);
    end

    regZeroPort1: assert property (
        @(posedge clk) disable iff (reset) (raddr1 == mipsIsaPkg::regZero) |-> (rdata1 == '0)
    ) else $error("registerFile: r0 read nonzero on port 1");

    regZeroPort2: assert property (
        @(posedge clk) disable iff (reset) (raddr2 == mipsIsaPkg::regZero) |-> (rdata2 == '0)
    ) else $error("registerFile: r0 read nonzero on port 2");

endmodule

//--- hw/stageReg.sv
`timescale 1ns/10ps

module stageReg #(
    parameter type payloadT = logic,
    parameter bit  holdUsed = 1'b0
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    hold,
    input  logic    clear,
    input  payloadT d,
    output payloadT q
);

    // Clear beats hold, hold beats load
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q <= '0;
        end else if (clear) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

    // Hazard logic never asks to keep and flush the same slot
    holdClearExclusive: assert property (
        @(posedge clk) disable iff (reset) holdUsed |-> !(hold && clear)
    ) else $error("stageReg: hold and clear requested together");

endmodule

//--- tests/mipsCoreTb.sv
`timescale 1ns/10ps

module mipsCoreTb;

    localparam int bodyLen        = 32;
    // Random body, seven final stores, closing loop
    localparam int progLen        = bodyLen + 8;
    localparam int memWords       = 64;
    localparam int dataWords      = 32;
    localparam int watchdogCycles = 8 * progLen + 100;

    logic                 clk;
    logic                 reset;
    mipsIsaPkg::wordT     instrAddr;
    mipsIsaPkg::wordT     instr;
    mipsPipePkg::dataReqT dataReq;
    mipsIsaPkg::wordT     readData;
    mipsIsaPkg::wordT     imem [memWords];
    mipsIsaPkg::wordT     dmem [dataWords];
    mipsIsaPkg::wordT     initMem [dataWords];
    logic [15:0]          lfsrState = 16'd25209;
    int                   errorCount;
    int                   pendingStores;
    logic                 modelReady;

    mipsCore #(.resetPc(32'h0)) mipsCore_inst (
        .clk(clk), .reset(reset), .instrAddr(instrAddr), .instr(instr),
        .dataReq(dataReq), .readData(readData)
    );

    storeChecker #(.memWords(memWords), .dataWords(dataWords)) storeChecker_inst (
        .clk(clk), .reset(reset), .programWords(imem), .initMem(initMem),
        .dataReq(dataReq), .errorCount(errorCount), .pendingStores(pendingStores),
        .modelReady(modelReady)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ****************************************
    // Memory models
    // ****************************************

    // Combinational reads
    assign instr    = imem[instrAddr[7:2]];
    assign readData = dmem[dataReq.address[6:2]];

    initial begin
        // Fill depends on every address bit
        for (int i = 0; i < dataWords; i++) begin
            initMem[i] = (32'(i) * 32'h9E37_79B1) ^ 32'h00C3_A500;
            dmem[i]    = initMem[i];
        end
        forever begin
            @(posedge clk);
            if (dataReq.writeEnable) begin
                dmem[dataReq.address[6:2]] <= dataReq.writeData;
            end
        end
    end

    // ****************************************
    // Program generator
    // ****************************************

    // Galois LFSR, 16 bits
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // One step per bit taken
    task automatic takeBits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v         = {v[14:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    function automatic mipsIsaPkg::wordT encodeR(input mipsIsaPkg::regIdxT rs,
        input mipsIsaPkg::regIdxT rt, input mipsIsaPkg::regIdxT rd,
        input mipsIsaPkg::functT fn);
        return {mipsIsaPkg::opRType, rs, rt, rd, 5'b00000, fn};
    endfunction

    function automatic mipsIsaPkg::wordT encodeI(input mipsIsaPkg::opcodeT op,
        input mipsIsaPkg::regIdxT rs, input mipsIsaPkg::regIdxT rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Destinations 1 to 7, sources 0 to 7
    function automatic mipsIsaPkg::regIdxT destReg(input logic [15:0] v);
        return (v[2:0] == 3'd0) ? 5'd1 : {2'b00, v[2:0]};
    endfunction

    function automatic mipsIsaPkg::regIdxT srcReg(input logic [15:0] v);
        return {2'b00, v[2:0]};
    endfunction

    function automatic mipsIsaPkg::functT pickFunct(input logic [15:0] v);
        case (v[2:0])
            3'd0, 3'd1: return mipsIsaPkg::fnAdd;
            3'd2:       return mipsIsaPkg::fnSub;
            3'd3:       return mipsIsaPkg::fnAnd;
            3'd4:       return mipsIsaPkg::fnOr;
            default:    return mipsIsaPkg::fnSlt;
        endcase
    endfunction

    task automatic buildProgram();
        logic [15:0] kind;
        logic [15:0] r1;
        logic [15:0] r2;
        logic [15:0] r3;
        logic [15:0] bits;
        int          idx;
        int          off;
        for (int i = 0; i < memWords; i++) begin
            imem[i] = '0;
        end
        idx = 0;
        while (idx < bodyLen) begin
            takeBits(3, kind);
            takeBits(3, r1);
            takeBits(3, r2);
            takeBits(3, r3);
            case (kind[2:0])
                3'd0, 3'd1, 3'd2: begin
                    takeBits(3, bits);
                    imem[idx] = encodeR(srcReg(r1), srcReg(r2), destReg(r3), pickFunct(bits));
                end
                3'd4: begin
                    takeBits(4, bits);
                    imem[idx] = encodeI(mipsIsaPkg::opLw, 5'd0, destReg(r3),
                                        {10'b0, bits[3:0], 2'b00});
                    // Immediate use of the loaded register
                    if (idx < bodyLen - 1) begin
                        idx++;
                        takeBits(16, bits);
                        imem[idx] = encodeI(mipsIsaPkg::opAddi, destReg(r3), destReg(r1), bits);
                    end
                end
                3'd5: begin
                    takeBits(4, bits);
                    imem[idx] = encodeI(mipsIsaPkg::opSw, 5'd0, srcReg(r1),
                                        {10'b0, bits[3:0], 2'b00});
                end
                3'd6: begin
                    takeBits(2, bits);
                    off = (bits[1:0] == 2'd3) ? 1 : int'(bits[1:0]) + 1;
                    // Target stays inside the random body
                    if (off > bodyLen - idx - 1) begin
                        off = bodyLen - idx - 1;
                    end
                    imem[idx] = encodeI(mipsIsaPkg::opBeq, srcReg(r1), srcReg(r2), 16'(off));
                end
                default: begin
                    takeBits(16, bits);
                    imem[idx] = encodeI(mipsIsaPkg::opAddi, srcReg(r1), destReg(r3), bits);
                end
            endcase
            idx++;
        end
        // Dump every register to words 16 to 22
        for (int r = 1; r < 8; r++) begin
            imem[bodyLen + r - 1] = encodeI(mipsIsaPkg::opSw, 5'd0, 5'(r), 16'((15 + r) * 4));
        end
        imem[bodyLen + 7] = encodeI(mipsIsaPkg::opBeq, 5'd0, 5'd0, 16'hFFFF);
    endtask

    // ****************************************
    // Sequence and watchdog
    // ****************************************

    initial begin
        reset = 1'b1;
        buildProgram();
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        // Done once the model's store stream is used up
        wait (modelReady && pendingStores == 0);
        repeat (10) @(posedge clk);
        $display("Store check: %0d store errors, %0d missing stores", errorCount, pendingStores);
        if (errorCount == 0 && pendingStores == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        repeat (16 + watchdogCycles) @(posedge clk);
        $display("ERROR: watchdog expired with %0d expected stores never seen", pendingStores);
        $display("Store check: %0d store errors, %0d missing stores", errorCount, pendingStores);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- tests/storeChecker.sv
`timescale 1ns/10ps

module storeChecker #(
    parameter int memWords  = 64,
    parameter int dataWords = 32
) (
    input  logic                 clk,
    input  logic                 reset,
    input  mipsIsaPkg::wordT     programWords [memWords],
    input  mipsIsaPkg::wordT     initMem [dataWords],
    input  mipsPipePkg::dataReqT dataReq,
    output int                   errorCount,
    output int                   pendingStores,
    output logic                 modelReady
);

    // Expected store stream in program order
    mipsIsaPkg::wordT expAddr [$];
    mipsIsaPkg::wordT expData [$];

    // ****************************************
    // Instruction-set model
    // ****************************************

    task automatic buildModel();
        mipsIsaPkg::wordT regs [32];
        mipsIsaPkg::wordT mem [dataWords];
        mipsIsaPkg::wordT w;
        mipsIsaPkg::wordT a;
        mipsIsaPkg::wordT b;
        mipsIsaPkg::wordT imm;
        mipsIsaPkg::wordT addr;
        mipsIsaPkg::wordT r;
        mipsIsaPkg::wordT loopInstr;
        int pc;
        loopInstr = {mipsIsaPkg::opBeq, 5'd0, 5'd0, 16'hFFFF};
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < dataWords; i++) begin
            mem[i] = initMem[i];
        end
        pc = 0;
        // Stop at the closing self loop
        while (pc < memWords && programWords[pc] != loopInstr) begin
            w    = programWords[pc];
            a    = regs[w[25:21]];
            b    = regs[w[20:16]];
            imm  = {{16{w[15]}}, w[15:0]};
            addr = a + imm;
            pc   = pc + 1;
            case (w[31:26])
                mipsIsaPkg::opRType: begin
                    case (w[5:0])
                        mipsIsaPkg::fnAdd: r = a + b;
                        mipsIsaPkg::fnSub: r = a - b;
                        mipsIsaPkg::fnAnd: r = a & b;
                        mipsIsaPkg::fnOr:  r = a | b;
                        // Signed less-than
                        default:           r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    endcase
                    regs[w[15:11]] = r;
                end
                mipsIsaPkg::opAddi: regs[w[20:16]] = addr;
                mipsIsaPkg::opLw:   regs[w[20:16]] = mem[addr[6:2]];
                mipsIsaPkg::opSw: begin
                    mem[addr[6:2]] = b;
                    expAddr.push_back(addr);
                    expData.push_back(b);
                end
                mipsIsaPkg::opBeq: begin
                    // Offset in words past the branch
                    if (a == b) begin
                        pc = pc + int'(imm);
                    end
                end
                default: ;
            endcase
            regs[0] = '0;
        end
    endtask

    // ****************************************
    // Store comparison
    // ****************************************

    task automatic checkStore();
        mipsIsaPkg::wordT ea;
        mipsIsaPkg::wordT ed;
        if (dataReq.writeEnable) begin
            if (reset) begin
                $display("ERROR at %0t: store to %h issued while reset is active",
                         $time, dataReq.address);
                errorCount++;
            end else if (expAddr.size() == 0) begin
                $display("ERROR at %0t: extra store to %h, the model has no store left",
                         $time, dataReq.address);
                errorCount++;
            end else begin
                ea = expAddr.pop_front();
                ed = expData.pop_front();
                if (dataReq.address !== ea) begin
                    $display("FAIL %0t dataReq.address expected %h got %h",
                             $time, ea, dataReq.address);
                    errorCount++;
                end
                if (dataReq.writeData !== ed) begin
                    $display("FAIL %0t dataReq.writeData expected %h got %h",
                             $time, ed, dataReq.writeData);
                    errorCount++;
                end
            end
        end
    endtask

    // Sample mid-cycle where the request is stable
    initial begin
        errorCount    = 0;
        pendingStores = 0;
        modelReady    = 1'b0;
        // First full clock period, program and data image are settled by then
        @(posedge clk);
        @(negedge clk);
        buildModel();
        modelReady = 1'b1;
        forever begin
            checkStore();
            pendingStores = expAddr.size();
            @(negedge clk);
        end
    end

endmodule
